// File: vlog.f
hw/lc4_isa_pkg.sv
hw/lc4_pipe_pkg.sv
hw/lc4_fetch.sv
hw/lc4_decoder.sv
hw/lc4_regfile.sv
hw/lc4_alu.sv
hw/lc4_execute.sv
hw/lc4_writeback.sv
hw/lc4_core.sv
test/tb_clock.sv
test/tb_lc4_core.sv

// File: Bender.yml
package:
  name: lc4_core

sources:
  - files:
      - hw/lc4_isa_pkg.sv
      - hw/lc4_pipe_pkg.sv
      - hw/lc4_fetch.sv
      - hw/lc4_decoder.sv
      - hw/lc4_regfile.sv
      - hw/lc4_alu.sv
      - hw/lc4_execute.sv
      - hw/lc4_writeback.sv
      - hw/lc4_core.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/tb_lc4_core.sv

// File: test/tb_lc4_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lc4_core;

  import lc4_isa_pkg::*;
  import lc4_pipe_pkg::*;

  localparam int n_retire       = 400;  // Retirements before the run ends
  localparam int retire_timeout = 20;   // Cycles allowed between retirements
  localparam logic [15:0] reset_pc = 16'h8200;  // First fetch address of the ISA

  logic            gwe;
  logic            rst_n;
  insn_t           imem_data;
  logic [xlen-1:0] imem_addr;
  result_t         retire;

  logic [15:0] prog [256];    // Program memory, indexed by PC bits 7:0
  logic [15:0] m_regs [8];    // Model register file
  logic [15:0] m_pc;          // Model PC
  nzp_t        m_nzp;         // Model condition codes
  int          seed = 78;
  int          errors = 0;
  int          retired = 0;
  int          taken = 0;     // Taken branches seen by the model
  bit          timed_out = 1'b0;

  tb_clock u_clock (.o_gwe(gwe), .o_rst_n(rst_n));

  lc4_core DUT (
    .gwe         (gwe),
    .i_rst_n     (rst_n),
    .i_imem_data (imem_data),
    .o_imem_addr (imem_addr),
    .o_retire    (retire)
  );

  // Word follows the PC, which only moves in the rising-edge time step
  always @(imem_addr) imem_data <= prog[imem_addr[7:0]];

  // Random mix of CONST, ARITH, LOGIC and short forward BR words
  task automatic gen_program();
    logic [2:0] kind;
    logic [2:0] rd;
    logic [2:0] rs;
    logic [2:0] rt;
    logic [8:0] imm9;
    for (int i = 0; i < 256; i++) begin
      kind = 3'($random(seed));
      rd   = 3'($random(seed));
      rs   = 3'($random(seed));
      rt   = 3'($random(seed));
      imm9 = 9'($random(seed));
      case (kind)
        3'd0, 3'd1: prog[i] = {4'b1001, rd, imm9};
        3'd2, 3'd3: prog[i] = imm9[8] ? {4'b0001, rd, rs, 1'b1, imm9[4:0]}
                                      : {4'b0001, rd, rs, 1'b0, imm9[5], 1'b0, rt};  // ADD, SUB
        3'd4, 3'd5: prog[i] = imm9[8] ? {4'b0101, rd, rs, 1'b1, imm9[4:0]}
                                      : {4'b0101, rd, rs, 1'b0, imm9[4:3], rt};
        default:    prog[i] = {4'b0000, rd, 7'd0, imm9[1:0]};  // rd bits act as NZP mask
      endcase
    end
  endtask

  // One ISA step: expected retire contents, then architectural update
  task automatic model_step(output result_t want);
    logic [15:0] w;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] imm5;
    logic [15:0] imm9;
    w    = prog[m_pc[7:0]];
    a    = m_regs[w[8:6]];
    b    = m_regs[w[2:0]];
    imm5 = {{11{w[4]}}, w[4:0]};
    imm9 = {{7{w[8]}}, w[8:0]};
    want            = '0;
    want.valid      = 1'b1;
    want.pc         = m_pc;
    want.insn       = w;
    want.wsel       = w[11:9];
    want.regfile_we = 1'b1;
    case (w[15:12])
      4'b0001: want.result = w[5] ? a + imm5 : (w[4:3] == 2'b10) ? a - b : a + b;
      4'b0101: begin
        if (w[5]) want.result = a & imm5;
        else begin
          case (w[4:3])
            2'b00:   want.result = a & b;
            2'b01:   want.result = ~a;
            2'b10:   want.result = a | b;
            default: want.result = a ^ b;
          endcase
        end
      end
      4'b1001: want.result = imm9;
      default: want.regfile_we = 1'b0;  // BR writes nothing
    endcase
    want.nzp_we = want.regfile_we;
    if (want.regfile_we) begin
      want.nzp = want.result[15] ? 3'b100 : (want.result == 16'd0) ? 3'b010 : 3'b001;
      m_regs[want.wsel] = want.result;
      m_nzp = want.nzp;
      m_pc  = m_pc + 16'd1;
    end else if ((w[11:9] & m_nzp) != 3'b000) begin
      m_pc = m_pc + 16'd1 + imm9;  // Taken
      taken++;
    end else begin
      m_pc = m_pc + 16'd1;
    end
  endtask

  task automatic check_field(input string name, input logic [15:0] want_v,
                             input logic [15:0] got_v);
    if (got_v !== want_v) begin
      errors++;
      $display("[ERROR] %s expected %h got %h (model pc %h)", name, want_v, got_v, m_pc);
    end
  endtask

  task automatic check_retire(input result_t want);
    check_field("o_retire.pc", want.pc, retire.pc);
    check_field("o_retire.insn", want.insn, retire.insn);
    check_field("o_retire.regfile_we", 16'(want.regfile_we), 16'(retire.regfile_we));
    check_field("o_retire.nzp_we", 16'(want.nzp_we), 16'(retire.nzp_we));
    if (want.regfile_we) begin  // Fields below are don't-care for BR
      check_field("o_retire.wsel", 16'(want.wsel), 16'(retire.wsel));
      check_field("o_retire.result", want.result, retire.result);
    end
    if (want.nzp_we) check_field("o_retire.nzp", 16'(want.nzp), 16'(retire.nzp));
  endtask

  // Samples at the falling edge, outputs are settled there
  task automatic wait_reset();
    int n;
    n = 0;
    @(negedge gwe);
    while (!rst_n && n < 10) begin
      n++;
      @(negedge gwe);
    end
    if (!rst_n) begin
      timed_out = 1'b1;
      errors++;
      $display("Timeout: reset was never released");
    end
  endtask

  task automatic wait_retire(output int waited);
    waited = 0;
    while (!retire.valid && waited < retire_timeout) begin
      waited++;
      @(negedge gwe);
    end
    if (!retire.valid) begin
      timed_out = 1'b1;
      errors++;
      $display("Timeout: no instruction retired within %0d cycles", retire_timeout);
    end
  endtask

  initial begin
    result_t want;
    int      waited;
    imem_data <= nop_insn;
    gen_program();
    m_pc  = reset_pc;
    m_nzp = 3'b000;
    for (int i = 0; i < 8; i++) m_regs[i] = '0;
    wait_reset();
    if (!timed_out) begin
      check_field("o_imem_addr", reset_pc, imem_addr);  // First cycle out of reset
      wait_retire(waited);
      check_field("o_retire.valid low cycles", 16'd4, 16'(waited));
    end
    while (!timed_out && retired < n_retire) begin
      model_step(want);
      check_retire(want);
      retired++;
      if (retired < n_retire) begin
        @(negedge gwe);
        wait_retire(waited);
      end
    end
    $display("Retired %0d, taken branches %0d, errors %0d", retired, taken, errors);
    if (errors == 0) $display("sim passed");
    else $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic o_gwe,    // 8 ns period
  output logic o_rst_n   // Low for the first two rising edges
);

  initial begin
    o_gwe = 1'b0;
    forever #4 o_gwe = ~o_gwe;
  end

  initial begin
    o_rst_n = 1'b0;
    repeat (2) @(posedge o_gwe);
    o_rst_n <= 1'b1;  // Released on the edge, like any other input
  end

endmodule

`default_nettype wire

// File: hw/lc4_core.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_core (
  input  logic                           gwe,
  input  logic                           i_rst_n,
  input  lc4_isa_pkg::insn_t             i_imem_data,
  output logic [lc4_isa_pkg::xlen-1:0]   o_imem_addr,
  output lc4_pipe_pkg::result_t          o_retire
);

  import lc4_isa_pkg::*;
  import lc4_pipe_pkg::*;

  logic [xlen-1:0] d_pc;
  insn_t           d_insn;
  logic            d_valid;
  ctrl_t           d_ctrl;
  logic [xlen-1:0] rs_data;
  logic [xlen-1:0] rt_data;
  result_t         x_res;
  result_t         m_res;
  result_t         w_res;
  nzp_t            nzp;
  logic            flush;      // Taken branch in execute
  logic [xlen-1:0] br_target;

  lc4_fetch u_fetch (
    .gwe         (gwe),
    .i_rst_n     (i_rst_n),
    .i_flush     (flush),
    .i_target    (br_target),
    .i_imem_data (i_imem_data),
    .o_imem_addr (o_imem_addr),
    .o_d_pc      (d_pc),
    .o_d_insn    (d_insn),
    .o_d_valid   (d_valid)
  );

  lc4_decoder u_decoder (.i_insn(d_insn), .i_valid(d_valid), .o_ctrl(d_ctrl));

  lc4_regfile u_regfile (
    .gwe       (gwe),
    .i_rst_n   (i_rst_n),
    .i_rs_sel  (d_ctrl.r1sel),
    .i_rt_sel  (d_ctrl.r2sel),
    .i_wb      (w_res),
    .o_rs_data (rs_data),
    .o_rt_data (rt_data)
  );

  lc4_execute u_execute (
    .gwe (gwe), .i_rst_n (i_rst_n),
    .i_d_pc (d_pc), .i_d_insn (d_insn), .i_d_ctrl (d_ctrl),
    .i_rs_data (rs_data), .i_rt_data (rt_data),
    .i_m (m_res), .i_w (w_res), .i_nzp (nzp),
    .o_x (x_res), .o_flush (flush), .o_target (br_target)
  );

  lc4_writeback u_writeback (
    .gwe (gwe), .i_rst_n (i_rst_n), .i_x (x_res),
    .o_m (m_res), .o_w (w_res), .o_nzp (nzp)
  );

  assign o_retire = w_res;  // Writeback stage is the retire point

endmodule

`default_nettype wire

// File: hw/lc4_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_writeback (
  input  logic                    gwe,
  input  logic                    i_rst_n,
  input  lc4_pipe_pkg::result_t   i_x,    // Execute result
  output lc4_pipe_pkg::result_t   o_m,    // Memory stage, no data access here
  output lc4_pipe_pkg::result_t   o_w,    // Regfile write and retire trace
  output lc4_isa_pkg::nzp_t       o_nzp   // Committed condition codes
);

  import lc4_pipe_pkg::*;

  // Two stage shift, control bits cleared on reset
  always_ff @(posedge gwe) begin
    o_m <= i_x;
    o_w <= o_m;
    if (!i_rst_n) begin
      o_m.valid      <= 1'b0;
      o_m.regfile_we <= 1'b0;
      o_m.nzp_we     <= 1'b0;
      o_w.valid      <= 1'b0;
      o_w.regfile_we <= 1'b0;
      o_w.nzp_we     <= 1'b0;
    end
  end

  // NZP commits with the register write
  always_ff @(posedge gwe) begin
    if (!i_rst_n) begin
      o_nzp <= '0;
    end else if (o_w.valid && o_w.nzp_we) begin
      o_nzp <= o_w.nzp;
    end
  end

endmodule

`default_nettype wire

// File: hw/lc4_execute.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_execute (
  input  logic                           gwe,
  input  logic                           i_rst_n,
  input  logic [lc4_isa_pkg::xlen-1:0]   i_d_pc,
  input  lc4_isa_pkg::insn_t             i_d_insn,
  input  lc4_pipe_pkg::ctrl_t            i_d_ctrl,
  input  logic [lc4_isa_pkg::xlen-1:0]   i_rs_data,
  input  logic [lc4_isa_pkg::xlen-1:0]   i_rt_data,
  input  lc4_pipe_pkg::result_t          i_m,       // Memory stage, youngest bypass source
  input  lc4_pipe_pkg::result_t          i_w,       // Writeback stage
  input  lc4_isa_pkg::nzp_t              i_nzp,     // Committed NZP
  output lc4_pipe_pkg::result_t          o_x,
  output logic                           o_flush,
  output logic [lc4_isa_pkg::xlen-1:0]   o_target
);

  import lc4_isa_pkg::*;
  import lc4_pipe_pkg::*;

  xstage_t         d_slot;
  xstage_t         x_q;
  logic [xlen-1:0] rs_byp;
  logic [xlen-1:0] rt_byp;
  logic [xlen-1:0] alu_out;
  nzp_t            x_nzp;
  nzp_t            br_nzp;

  // Pick the youngest valid writer of sel, else the register file value
  function automatic logic [xlen-1:0] bypass(reg_sel_t sel, logic [xlen-1:0] rf_data,
                                             result_t m, result_t w);
    if (m.valid && m.regfile_we && m.wsel == sel) return m.result;
    if (w.valid && w.regfile_we && w.wsel == sel) return w.result;
    return rf_data;
  endfunction

  assign d_slot = '{pc: i_d_pc, insn: i_d_insn, ctrl: i_d_ctrl,
                    rs_data: i_rs_data, rt_data: i_rt_data};

  always_ff @(posedge gwe) begin
    x_q <= d_slot;
    if (!i_rst_n || o_flush) begin  // Decode slot is wrong path on a flush
      x_q.ctrl <= '0;
      x_q.insn <= nop_insn;
    end
  end

  assign rs_byp = bypass(x_q.ctrl.r1sel, x_q.rs_data, i_m, i_w);
  assign rt_byp = bypass(x_q.ctrl.r2sel, x_q.rt_data, i_m, i_w);

  lc4_alu u_alu (
    .i_insn   (x_q.insn),
    .i_pc     (x_q.pc),
    .i_rs     (rs_byp),
    .i_rt     (rt_byp),
    .o_result (alu_out),
    .o_target (o_target)
  );

  // Sign rule on the result
  assign x_nzp = alu_out[xlen-1] ? 3'b100 : (alu_out == '0) ? 3'b010 : 3'b001;

  // Branch test sees the youngest NZP writer still in flight
  assign br_nzp = (i_m.valid && i_m.nzp_we) ? i_m.nzp :
                  (i_w.valid && i_w.nzp_we) ? i_w.nzp : i_nzp;

  assign o_flush = x_q.ctrl.is_valid && x_q.ctrl.is_branch &&
                   |(x_q.insn.imm_fmt.rd_nzp & br_nzp);

  assign o_x = '{valid: x_q.ctrl.is_valid, pc: x_q.pc, insn: x_q.insn,
                 regfile_we: x_q.ctrl.regfile_we, wsel: x_q.ctrl.wsel, result: alu_out,
                 nzp_we: x_q.ctrl.nzp_we, nzp: x_nzp};

endmodule

`default_nettype wire

// File: hw/lc4_alu.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_alu (
  input  lc4_isa_pkg::insn_t             i_insn,
  input  logic [lc4_isa_pkg::xlen-1:0]   i_pc,
  input  logic [lc4_isa_pkg::xlen-1:0]   i_rs,
  input  logic [lc4_isa_pkg::xlen-1:0]   i_rt,
  output logic [lc4_isa_pkg::xlen-1:0]   o_result,
  output logic [lc4_isa_pkg::xlen-1:0]   o_target   // PC + 1 + imm9
);

  import lc4_isa_pkg::*;

  logic [xlen-1:0] imm5_sext;
  logic [xlen-1:0] imm9_sext;

  // imm5 overlays the sub-op and rt fields
  assign imm5_sext = {{11{i_insn.rrr_fmt.sub_op[1]}}, i_insn.rrr_fmt.sub_op, i_insn.rrr_fmt.rt};
  assign imm9_sext = {{7{i_insn.imm_fmt.imm9[8]}}, i_insn.imm_fmt.imm9};
  assign o_target  = i_pc + 16'd1 + imm9_sext;

  always_comb begin
    o_result = '0;
    case (i_insn.rrr_fmt.opcode)
      op_arith: begin
        if (i_insn.rrr_fmt.imm) o_result = i_rs + imm5_sext;  // ADD imm
        else if (i_insn.rrr_fmt.sub_op == sub_add) o_result = i_rs + i_rt;
        else if (i_insn.rrr_fmt.sub_op == sub_sub) o_result = i_rs - i_rt;
      end
      op_logic: begin
        if (i_insn.rrr_fmt.imm) o_result = i_rs & imm5_sext;  // AND imm
        else begin
          case (i_insn.rrr_fmt.sub_op)
            sub_and: o_result = i_rs & i_rt;
            sub_not: o_result = ~i_rs;
            sub_or:  o_result = i_rs | i_rt;
            default: o_result = i_rs ^ i_rt;  // XOR
          endcase
        end
      end
      op_const: o_result = imm9_sext;
      default:  o_result = '0;  // BR and unknown words write nothing
    endcase
  end

endmodule

`default_nettype wire

// File: hw/lc4_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_regfile (
  input  logic                          gwe,
  input  logic                          i_rst_n,
  input  lc4_isa_pkg::reg_sel_t         i_rs_sel,
  input  lc4_isa_pkg::reg_sel_t         i_rt_sel,
  input  lc4_pipe_pkg::result_t         i_wb,       // Writeback stage contents
  output logic [lc4_isa_pkg::xlen-1:0]  o_rs_data,
  output logic [lc4_isa_pkg::xlen-1:0]  o_rt_data
);

  import lc4_isa_pkg::*;
  import lc4_pipe_pkg::*;

  logic [xlen-1:0] regs [8];  // R0 to R7
  logic            wr_en;

  assign wr_en = i_wb.valid && i_wb.regfile_we;

  always_ff @(posedge gwe) begin
    if (!i_rst_n) regs <= '{default: '0};
    else if (wr_en) regs[i_wb.wsel] <= i_wb.result;
  end

  // Write-through so decode sees the value retiring this cycle
  assign o_rs_data = (wr_en && i_wb.wsel == i_rs_sel) ? i_wb.result : regs[i_rs_sel];
  assign o_rt_data = (wr_en && i_wb.wsel == i_rt_sel) ? i_wb.result : regs[i_rt_sel];

endmodule

`default_nettype wire

// File: hw/lc4_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_decoder (
  input  lc4_isa_pkg::insn_t    i_insn,
  input  logic                  i_valid,
  output lc4_pipe_pkg::ctrl_t   o_ctrl
);

  import lc4_isa_pkg::*;
  import lc4_pipe_pkg::*;

  logic writes;  // Opcode produces a register and NZP result

  always_comb begin
    writes          = 1'b0;
    o_ctrl          = '0;
    o_ctrl.r1sel    = i_insn.rrr_fmt.rs;
    o_ctrl.r2sel    = i_insn.rrr_fmt.rt;
    o_ctrl.wsel     = i_insn.rrr_fmt.rd;  // Same bits as CONST rd
    o_ctrl.is_valid = i_valid;
    case (i_insn.rrr_fmt.opcode)
      op_br:    o_ctrl.is_branch = i_valid;
      // MUL and DIV fall out as no-write slots
      op_arith: writes = i_insn.rrr_fmt.imm ||
                         i_insn.rrr_fmt.sub_op == sub_add ||
                         i_insn.rrr_fmt.sub_op == sub_sub;
      op_logic: writes = 1'b1;  // All four sub-ops kept
      op_const: writes = 1'b1;
      default:  writes = 1'b0;  // Unknown opcode, no side effects
    endcase
    o_ctrl.regfile_we = i_valid && writes;
    o_ctrl.nzp_we     = i_valid && writes;  // Every writer also sets NZP
  end

endmodule

`default_nettype wire

// File: hw/lc4_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_fetch (
  input  logic                           gwe,
  input  logic                           i_rst_n,
  input  logic                           i_flush,      // Taken branch in execute
  input  logic [lc4_isa_pkg::xlen-1:0]   i_target,     // Branch target
  input  lc4_isa_pkg::insn_t             i_imem_data,  // Word at o_imem_addr, same cycle
  output logic [lc4_isa_pkg::xlen-1:0]   o_imem_addr,
  output logic [lc4_isa_pkg::xlen-1:0]   o_d_pc,
  output lc4_isa_pkg::insn_t             o_d_insn,
  output logic                           o_d_valid
);

  import lc4_isa_pkg::*;

  logic [xlen-1:0] pc_q;
  logic [xlen-1:0] pc_next;

  // Redirect wins over sequential fetch
  assign pc_next     = i_flush ? i_target : pc_q + 16'd1;
  assign o_imem_addr = pc_q;

  // PC and decode valid
  always_ff @(posedge gwe) begin
    if (!i_rst_n) begin
      pc_q      <= rst_pc;
      o_d_valid <= 1'b0;
    end else begin
      pc_q      <= pc_next;
      o_d_valid <= !i_flush;  // Word fetched under a flush is wrong path
    end
  end

  // Fetch to decode payload
  always_ff @(posedge gwe) begin
    o_d_pc   <= pc_q;
    o_d_insn <= i_flush ? nop_insn : i_imem_data;
  end

endmodule

`default_nettype wire

// File: hw/lc4_pipe_pkg.sv
`default_nettype none

package lc4_pipe_pkg;

  import lc4_isa_pkg::*;

  // Decoded control, 13 bits
  typedef struct packed {
    reg_sel_t r1sel;       // rs select
    reg_sel_t r2sel;       // rt select
    reg_sel_t wsel;        // Destination register
    logic     regfile_we;
    logic     nzp_we;
    logic     is_branch;
    logic     is_valid;    // Low for squashed and reset slots
  } ctrl_t;

  // Decode to execute register, 77 bits
  typedef struct packed {
    logic [xlen-1:0] pc;
    insn_t           insn;
    ctrl_t           ctrl;
    logic [xlen-1:0] rs_data;
    logic [xlen-1:0] rt_data;
  } xstage_t;

  // Result of one instruction, memory and writeback stages and retire trace
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    insn_t           insn;
    logic            regfile_we;
    reg_sel_t        wsel;
    logic [xlen-1:0] result;
    logic            nzp_we;
    nzp_t            nzp;
  } result_t;

endpackage

`default_nettype wire

// File: hw/lc4_isa_pkg.sv
`default_nettype none

package lc4_isa_pkg;

  localparam int xlen = 16;  // Data and address width

  typedef logic [2:0] reg_sel_t;  // Register number
  typedef logic [2:0] nzp_t;      // Condition codes, N in bit 2

  // Only the four opcode groups the core executes
  typedef enum logic [3:0] {
    op_br    = 4'b0000,  // BR, NZP 000 is the NOP
    op_arith = 4'b0001,  // ADD, SUB, ADD imm
    op_logic = 4'b0101,  // AND, NOT, OR, XOR, AND imm
    op_const = 4'b1001   // CONST with imm9
  } opcode_t;

  // Sub-op in bits 4:3 when the imm flag is clear
  localparam logic [1:0] sub_add = 2'b00;
  localparam logic [1:0] sub_sub = 2'b10;  // MUL 01 and DIV 11 are not kept
  localparam logic [1:0] sub_and = 2'b00;
  localparam logic [1:0] sub_not = 2'b01;
  localparam logic [1:0] sub_or  = 2'b10;
  localparam logic [1:0] sub_xor = 2'b11;

  // One instruction word, seen as register or immediate format
  typedef union packed {
    struct packed {
      opcode_t          opcode;
      reg_sel_t         rd;
      reg_sel_t         rs;
      logic             imm;     // Set for the imm5 forms
      logic [1:0]       sub_op;  // Upper two bits of imm5 when imm is set
      reg_sel_t         rt;      // Lower three bits of imm5 when imm is set
    } rrr_fmt;
    struct packed {
      opcode_t          opcode;
      logic [2:0]       rd_nzp;  // rd for CONST, NZP mask for BR
      logic [8:0]       imm9;
    } imm_fmt;
  } insn_t;

  localparam logic [xlen-1:0] rst_pc = 16'h8200;  // PC out of reset
  localparam insn_t nop_insn = '0;  // BR with empty mask

endpackage

`default_nettype wire
